// File: rtl/llc_pkg.sv
////////////////////////////////////////
// LLC data ways shared definitions
////////////////////////////////////////
package llc_pkg;

  // cache units that talk to the data ways
  localparam int unsigned NUM_UNITS = 4;

  // lane numbering, also used to tag read responses
  typedef enum logic [1:0] {
    EVICT_UNIT  = 2'd0,  // reads a line out before replacement
    REFILL_UNIT = 2'd1,  // writes refill data from memory
    WCHAN_UNIT  = 2'd2,  // writes data of a write hit
    RCHAN_UNIT  = 2'd3   // reads data of a read hit
  } llc_unit_e;

  // evict and read channel only read, refill and write channel only write
  function automatic logic unit_is_reader(llc_unit_e unit);
    return (unit == EVICT_UNIT) || (unit == RCHAN_UNIT);
  endfunction

endpackage

// File: rtl/llc_rr_arbiter.sv
////////////////////////////////////////
// Round-robin arbiter for one way
////////////////////////////////////////
`timescale 1ns/100ps

module llc_rr_arbiter #(
  parameter int unsigned DataWidth = 32,
  parameter int unsigned NumLines  = 16
) (
  input  logic                                                  clk_i,
  input  logic                                                  rst_n_i,
  input  logic [llc_pkg::NUM_UNITS-1:0]                         req_i,  // unit valids
  output logic [llc_pkg::NUM_UNITS-1:0]                         gnt_o,  // unit readies
  input  logic [llc_pkg::NUM_UNITS-1:0][$clog2(NumLines)-1:0]   line_i,
  input  logic [llc_pkg::NUM_UNITS-1:0][DataWidth-1:0]          data_i,
  output logic                                                  valid_o,
  input  logic                                                  ready_i,
  output logic [$clog2(NumLines)-1:0]                           line_o,
  output logic [DataWidth-1:0]                                  data_o,
  output llc_pkg::llc_unit_e                                    unit_o
);
  import llc_pkg::*;

  logic [1:0] ptr_q;  // unit with highest priority
  logic [1:0] sel;    // unit picked this cycle
  logic       found;

  // first requesting unit at or after the pointer
  always_comb begin : find_comb
    logic [1:0] idx;
    idx   = ptr_q;
    sel   = ptr_q;
    found = 1'b0;
    for (int unsigned k = 0; k < NUM_UNITS; k++) begin
      idx = ptr_q + 2'(k);  // wraps around the four units
      if (!found && req_i[idx]) begin
        sel   = idx;
        found = 1'b1;
      end
    end
  end

  always_comb begin
    gnt_o      = '0;
    gnt_o[sel] = found & ready_i;  // grant only while the way can take it
  end

  assign valid_o = found;
  assign line_o  = line_i[sel];
  assign data_o  = data_i[sel];
  assign unit_o  = llc_unit_e'(sel);

  // move past the served unit so no lane starves
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ptr_q <= '0;
    end else if (found && ready_i) begin
      ptr_q <= sel + 2'd1;
    end
  end

endmodule

// File: rtl/llc_way_xbar.sv
////////////////////////////////////////
// Unit to way crossbar
////////////////////////////////////////
`timescale 1ns/100ps

module llc_way_xbar #(
  parameter int unsigned NumWays   = 4,
  parameter int unsigned NumLines  = 16,
  parameter int unsigned DataWidth = 32
) (
  input  logic                                                  clk_i,
  input  logic                                                  rst_n_i,
  // unit side
  input  logic [llc_pkg::NUM_UNITS-1:0]                         unit_valid_i,
  output logic [llc_pkg::NUM_UNITS-1:0]                         unit_ready_o,
  input  logic [llc_pkg::NUM_UNITS-1:0][NumWays-1:0]            unit_way_i,  // one-hot
  input  logic [llc_pkg::NUM_UNITS-1:0][$clog2(NumLines)-1:0]   unit_line_i,
  input  logic [llc_pkg::NUM_UNITS-1:0][DataWidth-1:0]          unit_data_i,
  // way side
  output logic [NumWays-1:0]                                    way_valid_o,
  input  logic [NumWays-1:0]                                    way_ready_i,
  output logic [NumWays-1:0][$clog2(NumLines)-1:0]              way_line_o,
  output logic [NumWays-1:0][DataWidth-1:0]                     way_data_o,
  output llc_pkg::llc_unit_e [NumWays-1:0]                      way_unit_o
);
  import llc_pkg::*;

  // valid and grant matrices, once per unit and once per way
  logic [NUM_UNITS-1:0][NumWays-1:0] unit_req, unit_gnt;
  logic [NumWays-1:0][NUM_UNITS-1:0] way_req,  way_gnt;

  for (genvar u = 0; u < NUM_UNITS; u++) begin : gen_unit
    // demux: valid only towards the indicated way
    assign unit_req[u] = unit_way_i[u] & {NumWays{unit_valid_i[u]}};

    for (genvar w = 0; w < NumWays; w++) begin : gen_cross
      assign way_req[w][u]  = unit_req[u][w];
      assign unit_gnt[u][w] = way_gnt[w][u];
    end

    // idle lanes see ready, a waiting lane gets the grant of its way
    assign unit_ready_o[u] = ~unit_valid_i[u] | (|unit_gnt[u]);
  end

  for (genvar w = 0; w < NumWays; w++) begin : gen_way_arb
    llc_rr_arbiter #(
      .DataWidth ( DataWidth ),
      .NumLines  ( NumLines  )
    ) i_arbiter (
      .clk_i   ( clk_i          ),
      .rst_n_i ( rst_n_i        ),
      .req_i   ( way_req[w]     ),
      .gnt_o   ( way_gnt[w]     ),
      .line_i  ( unit_line_i    ),
      .data_i  ( unit_data_i    ),
      .valid_o ( way_valid_o[w] ),
      .ready_i ( way_ready_i[w] ),
      .line_o  ( way_line_o[w]  ),
      .data_o  ( way_data_o[w]  ),
      .unit_o  ( way_unit_o[w]  )
    );
  end

endmodule

// File: rtl/llc_data_way.sv
////////////////////////////////////////
// Single data way
////////////////////////////////////////
`timescale 1ns/100ps

module llc_data_way #(
  parameter int unsigned NumLines  = 16,
  parameter int unsigned DataWidth = 32
) (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  // request from the arbiter
  input  logic                        inp_valid_i,
  output logic                        inp_ready_o,
  input  logic [$clog2(NumLines)-1:0] inp_line_i,
  input  logic [DataWidth-1:0]        inp_data_i,
  input  llc_pkg::llc_unit_e          inp_unit_i,
  // read response towards the router
  output logic                        out_valid_o,
  input  logic                        out_ready_i,
  output logic [DataWidth-1:0]        out_data_o,
  output llc_pkg::llc_unit_e          out_unit_o
);
  import llc_pkg::*;

  logic [DataWidth-1:0] mem_q [NumLines];  // single-port word array

  logic                 out_valid_q;
  logic [DataWidth-1:0] out_data_q;
  llc_unit_e            out_unit_q;  // who asked for the word

  logic xfer;
  logic is_read;

  // take a new request when the output slot is free or freed this cycle
  assign inp_ready_o = ~out_valid_q | out_ready_i;
  assign xfer        = inp_valid_i & inp_ready_o;
  assign is_read     = unit_is_reader(inp_unit_i);

  always_ff @(posedge clk_i) begin
    if (xfer && !is_read) begin
      mem_q[inp_line_i] <= inp_data_i;  // write, no response
    end
  end

  // read word goes straight into the output register
  always_ff @(posedge clk_i) begin
    if (xfer && is_read) begin
      out_data_q <= mem_q[inp_line_i];
      out_unit_q <= inp_unit_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_valid_q <= 1'b0;
    end else if (xfer && is_read) begin
      out_valid_q <= 1'b1;
    end else if (out_ready_i) begin
      out_valid_q <= 1'b0;  // drained by the router
    end
  end

  assign out_valid_o = out_valid_q;
  assign out_data_o  = out_data_q;
  assign out_unit_o  = out_unit_q;

endmodule

// File: rtl/llc_order_fifo.sv
////////////////////////////////////////
// Read order queue
////////////////////////////////////////
`timescale 1ns/100ps

module llc_order_fifo #(
  parameter int unsigned NumWays = 4
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               push_i,
  input  logic [NumWays-1:0] way_i,   // way of the accepted read
  input  logic               pop_i,
  output logic [NumWays-1:0] head_o,  // way of the oldest pending read
  output logic               full_o,
  output logic               empty_o
);

  localparam int unsigned PtrWidth = (NumWays > 1) ? $clog2(NumWays) : 1;
  localparam int unsigned CntWidth = $clog2(NumWays + 1);

  logic [NumWays-1:0]  fifo_q [NumWays];  // one slot per way is enough
  logic [PtrWidth-1:0] wr_ptr_q, rd_ptr_q;
  logic [CntWidth-1:0] cnt_q;

  assign full_o  = (cnt_q == CntWidth'(NumWays));
  assign empty_o = (cnt_q == '0);
  assign head_o  = fifo_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      fifo_q[wr_ptr_q] <= way_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(NumWays - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(NumWays - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push_i && !pop_i) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (pop_i && !push_i) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

endmodule

// File: rtl/llc_resp_router.sv
////////////////////////////////////////
// Read response router
////////////////////////////////////////
`timescale 1ns/100ps

module llc_resp_router #(
  parameter int unsigned NumWays   = 4,
  parameter int unsigned DataWidth = 32
) (
  // way outputs
  input  logic [NumWays-1:0]                 way_valid_i,
  output logic [NumWays-1:0]                 way_ready_o,
  input  logic [NumWays-1:0][DataWidth-1:0]  way_data_i,
  input  llc_pkg::llc_unit_e [NumWays-1:0]   way_unit_i,
  // order queues
  input  logic [NumWays-1:0]                 evict_head_i,
  input  logic                               evict_empty_i,
  output logic                               evict_pop_o,
  input  logic [NumWays-1:0]                 read_head_i,
  input  logic                               read_empty_i,
  output logic                               read_pop_o,
  // response channels
  output logic [DataWidth-1:0]               evict_data_o,
  output logic                               evict_valid_o,
  input  logic                               evict_ready_i,
  output logic [DataWidth-1:0]               read_data_o,
  output logic                               read_valid_o,
  input  logic                               read_ready_i
);
  import llc_pkg::*;

  // channel 0 serves the evict unit, channel 1 the read channel
  localparam llc_unit_e ChanUnit [2] = '{EVICT_UNIT, RCHAN_UNIT};

  logic [1:0][NumWays-1:0]   head;
  logic [1:0]                empty, ready, valid, pop;
  logic [1:0][DataWidth-1:0] data;

  assign head  = {read_head_i, evict_head_i};
  assign empty = {read_empty_i, evict_empty_i};
  assign ready = {read_ready_i, evict_ready_i};

  always_comb begin
    way_ready_o = '0;
    valid       = '0;
    data        = '0;
    pop         = '0;
    for (int unsigned c = 0; c < 2; c++) begin
      for (int unsigned m = 0; m < NumWays; m++) begin
        // only the head way, and only if its word belongs to this channel
        if (!empty[c] && head[c][m] && way_valid_i[m] && (way_unit_i[m] == ChanUnit[c])) begin
          valid[c] = 1'b1;
          data[c]  = way_data_i[m];
          if (ready[c]) begin
            way_ready_o[m] = 1'b1;  // drain the way and the queue together
            pop[c]         = 1'b1;
          end
        end
      end
    end
  end

  assign evict_valid_o = valid[0];
  assign evict_data_o  = data[0];
  assign evict_pop_o   = pop[0];
  assign read_valid_o  = valid[1];
  assign read_data_o   = data[1];
  assign read_pop_o    = pop[1];

endmodule

// File: rtl/llc_ways.sv
////////////////////////////////////////
// LLC data ways top level
////////////////////////////////////////
`timescale 1ns/100ps

module llc_ways #(
  parameter int unsigned NumWays   = 4,
  parameter int unsigned NumLines  = 16,
  parameter int unsigned DataWidth = 32
) (
  input  logic                                                  clk_i,
  input  logic                                                  rst_n_i,
  // unit requests, one lane per llc_unit_e
  input  logic [llc_pkg::NUM_UNITS-1:0][NumWays-1:0]            req_way_i,
  input  logic [llc_pkg::NUM_UNITS-1:0][$clog2(NumLines)-1:0]   req_line_i,
  input  logic [llc_pkg::NUM_UNITS-1:0][DataWidth-1:0]          req_data_i,
  input  logic [llc_pkg::NUM_UNITS-1:0]                         req_valid_i,
  output logic [llc_pkg::NUM_UNITS-1:0]                         req_ready_o,
  // evict response
  output logic [DataWidth-1:0]                                  evict_data_o,
  output logic                                                  evict_valid_o,
  input  logic                                                  evict_ready_i,
  // read channel response
  output logic [DataWidth-1:0]                                  read_data_o,
  output logic                                                  read_valid_o,
  input  logic                                                  read_ready_i
);
  import llc_pkg::*;

  logic [NUM_UNITS-1:0] unit_valid, unit_ready;
  logic [NUM_UNITS-1:0] unit_block;  // reader lane with a full order queue

  logic [NumWays-1:0]                        way_valid, way_ready;
  logic [NumWays-1:0][$clog2(NumLines)-1:0]  way_line;
  logic [NumWays-1:0][DataWidth-1:0]         way_data;
  llc_unit_e [NumWays-1:0]                   way_unit;

  logic [NumWays-1:0]                        out_valid, out_ready;
  logic [NumWays-1:0][DataWidth-1:0]         out_data;
  llc_unit_e [NumWays-1:0]                   out_unit;

  logic [NumWays-1:0] evict_head, read_head;
  logic evict_full, evict_empty, evict_push, evict_pop;
  logic read_full,  read_empty,  read_push,  read_pop;

  // readers stop while every way may already hold one of their words
  for (genvar u = 0; u < NUM_UNITS; u++) begin : gen_gate
    localparam llc_unit_e Unit = llc_unit_e'(u);
    assign unit_block[u]  = unit_is_reader(Unit) &
                            ((Unit == EVICT_UNIT) ? evict_full : read_full);
    assign unit_valid[u]  = req_valid_i[u] & ~unit_block[u];
    assign req_ready_o[u] = unit_ready[u] & ~unit_block[u];
  end

  llc_way_xbar #(
    .NumWays   ( NumWays   ),
    .NumLines  ( NumLines  ),
    .DataWidth ( DataWidth )
  ) i_xbar (
    .clk_i        ( clk_i       ),
    .rst_n_i      ( rst_n_i     ),
    .unit_valid_i ( unit_valid  ),
    .unit_ready_o ( unit_ready  ),
    .unit_way_i   ( req_way_i   ),
    .unit_line_i  ( req_line_i  ),
    .unit_data_i  ( req_data_i  ),
    .way_valid_o  ( way_valid   ),
    .way_ready_i  ( way_ready   ),
    .way_line_o   ( way_line    ),
    .way_data_o   ( way_data    ),
    .way_unit_o   ( way_unit    )
  );

  for (genvar w = 0; w < NumWays; w++) begin : gen_way
    llc_data_way #(
      .NumLines  ( NumLines  ),
      .DataWidth ( DataWidth )
    ) i_data_way (
      .clk_i       ( clk_i        ),
      .rst_n_i     ( rst_n_i      ),
      .inp_valid_i ( way_valid[w] ),
      .inp_ready_o ( way_ready[w] ),
      .inp_line_i  ( way_line[w]  ),
      .inp_data_i  ( way_data[w]  ),
      .inp_unit_i  ( way_unit[w]  ),
      .out_valid_o ( out_valid[w] ),
      .out_ready_i ( out_ready[w] ),
      .out_data_o  ( out_data[w]  ),
      .out_unit_o  ( out_unit[w]  )
    );
  end

  // record the way of every accepted read, in order
  assign evict_push = req_valid_i[EVICT_UNIT] & req_ready_o[EVICT_UNIT];
  assign read_push  = req_valid_i[RCHAN_UNIT] & req_ready_o[RCHAN_UNIT];

  llc_order_fifo #(.NumWays(NumWays)) i_evict_order (
    .clk_i   ( clk_i                 ),
    .rst_n_i ( rst_n_i               ),
    .push_i  ( evict_push            ),
    .way_i   ( req_way_i[EVICT_UNIT] ),
    .pop_i   ( evict_pop             ),
    .head_o  ( evict_head            ),
    .full_o  ( evict_full            ),
    .empty_o ( evict_empty           )
  );

  llc_order_fifo #(.NumWays(NumWays)) i_read_order (
    .clk_i   ( clk_i                 ),
    .rst_n_i ( rst_n_i               ),
    .push_i  ( read_push             ),
    .way_i   ( req_way_i[RCHAN_UNIT] ),
    .pop_i   ( read_pop              ),
    .head_o  ( read_head             ),
    .full_o  ( read_full             ),
    .empty_o ( read_empty            )
  );

  llc_resp_router #(
    .NumWays   ( NumWays   ),
    .DataWidth ( DataWidth )
  ) i_router (
    .way_valid_i   ( out_valid     ),
    .way_ready_o   ( out_ready     ),
    .way_data_i    ( out_data      ),
    .way_unit_i    ( out_unit      ),
    .evict_head_i  ( evict_head    ),
    .evict_empty_i ( evict_empty   ),
    .evict_pop_o   ( evict_pop     ),
    .read_head_i   ( read_head     ),
    .read_empty_i  ( read_empty    ),
    .read_pop_o    ( read_pop      ),
    .evict_data_o  ( evict_data_o  ),
    .evict_valid_o ( evict_valid_o ),
    .evict_ready_i ( evict_ready_i ),
    .read_data_o   ( read_data_o   ),
    .read_valid_o  ( read_valid_o  ),
    .read_ready_i  ( read_ready_i  )
  );

endmodule

// File: bench/llc_ways_tb.sv
////////////////////////////////////////
// LLC data ways testbench
////////////////////////////////////////
`timescale 1ns/100ps

module llc_ways_tb;
  import llc_pkg::*;

  localparam int NUM_WAYS   = 4;
  localparam int NUM_LINES  = 16;
  localparam int DATA_W     = 32;
  localparam int WAY_W      = $clog2(NUM_WAYS);
  localparam int LINE_W     = $clog2(NUM_LINES);
  localparam int ENT_W      = WAY_W + LINE_W + DATA_W;  // way index, line, data
  localparam int SCRIPT_LEN = 512;
  localparam int LANE_LIMIT = 300;  // cycles one request may wait

  logic                               clk;
  logic                               rst_n;
  logic [NUM_UNITS-1:0][NUM_WAYS-1:0] req_way;
  logic [NUM_UNITS-1:0][LINE_W-1:0]   req_line;
  logic [NUM_UNITS-1:0][DATA_W-1:0]   req_data;
  logic [NUM_UNITS-1:0]               req_valid, req_ready;
  logic [DATA_W-1:0]                  evict_data, read_data;
  logic                               evict_valid, evict_ready, read_valid, read_ready;

  logic [ENT_W-1:0]  script_mem [NUM_UNITS][SCRIPT_LEN];  // pending requests per unit
  int                script_head [NUM_UNITS];
  int                script_tail [NUM_UNITS];
  int                lane_way [NUM_UNITS];   // way index of the request on the lane
  int                lane_wait [NUM_UNITS];
  logic              taken [NUM_UNITS];      // set by the monitor on a transfer
  int                xfer_cnt [NUM_UNITS];
  logic [DATA_W-1:0] model_mem [NUM_WAYS][NUM_LINES];  // reference contents
  logic [DATA_W-1:0] exp_evict[$];
  logic [DATA_W-1:0] exp_read[$];

  logic [31:0] rng_state;
  int          ev_mode, rd_mode;  // 0 random ready, 1 held low, 2 held high
  string       test_name;
  int          errors, err_base, n_tests, resp_cnt;

  llc_ways dut (
    .clk_i         ( clk         ),
    .rst_n_i       ( rst_n       ),
    .req_way_i     ( req_way     ),
    .req_line_i    ( req_line    ),
    .req_data_i    ( req_data    ),
    .req_valid_i   ( req_valid   ),
    .req_ready_o   ( req_ready   ),
    .evict_data_o  ( evict_data  ),
    .evict_valid_o ( evict_valid ),
    .evict_ready_i ( evict_ready ),
    .read_data_o   ( read_data   ),
    .read_valid_o  ( read_valid  ),
    .read_ready_i  ( read_ready  )
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] rand32();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  task automatic report_error(input string msg);
    errors++;
    $display("ERROR %s: %s", test_name, msg);
  endtask

  task automatic check_word(input string what, input logic [DATA_W-1:0] want,
                            input logic [DATA_W-1:0] got);
    if (got !== want) begin
      errors++;
      $display("FAIL %s %s: expected %h, actual %h", test_name, what, want, got);
    end
  endtask

  task automatic check_flag(input string what, input logic want, input logic got);
    if (got !== want) begin
      errors++;
      $display("FAIL %s %s: expected %b, actual %b", test_name, what, want, got);
    end
  endtask

  task automatic add_req(input int u, input int w, input int line, input logic [DATA_W-1:0] d);
    logic [WAY_W-1:0]  wf;
    logic [LINE_W-1:0] lf;
    wf = w[WAY_W-1:0];
    lf = line[LINE_W-1:0];
    script_mem[u][script_tail[u]] = {wf, lf, d};
    script_tail[u]++;
  endtask

  // one negedge step of the unit lanes and the response readies
  task automatic drive_step();
    logic [ENT_W-1:0] ent;
    for (int u = 0; u < NUM_UNITS; u++) begin
      if (taken[u]) begin
        req_valid[u] = 1'b0;  // transferred at the last edge
        taken[u]     = 1'b0;
      end else if (req_valid[u]) begin
        lane_wait[u]++;
        if (lane_wait[u] == LANE_LIMIT) begin
          report_error($sformatf("request of unit %0d never accepted", u));
        end
      end
      if (!req_valid[u] && script_head[u] != script_tail[u] && (rand32() % 4) != 0) begin
        ent = script_mem[u][script_head[u]];
        script_head[u]++;
        lane_way[u]  = ent[ENT_W-1 -: WAY_W];
        req_way[u]   = NUM_WAYS'(1) << ent[ENT_W-1 -: WAY_W];
        req_line[u]  = ent[DATA_W +: LINE_W];
        req_data[u]  = ent[DATA_W-1:0];
        req_valid[u] = 1'b1;
        lane_wait[u] = 0;
      end
    end
    evict_ready = (ev_mode == 0) ? ((rand32() % 3) != 0) : (ev_mode == 2);
    read_ready  = (rd_mode == 0) ? ((rand32() % 3) != 0) : (rd_mode == 2);
  endtask

  function automatic logic phase_idle();
    logic busy;
    busy = (req_valid != '0) || (exp_evict.size() != 0) || (exp_read.size() != 0);
    for (int u = 0; u < NUM_UNITS; u++) begin
      busy = busy | (script_head[u] != script_tail[u]);
    end
    return !busy;
  endfunction

  task automatic run_until_idle(input int limit);
    int cyc;
    cyc = 0;
    while (!phase_idle() && cyc < limit) begin
      @(negedge clk);
      drive_step();
      cyc++;
    end
    if (!phase_idle()) begin
      report_error($sformatf("timeout, traffic still pending after %0d cycles", limit));
    end
  endtask

  task automatic test_begin(input string name);
    test_name = name;
    err_base  = errors;
    n_tests++;
  endtask

  task automatic test_end();
    $display("%s: %0d errors", test_name, errors - err_base);
  endtask

  // reference model and response checks, sampled at the rising edge
  always @(posedge clk) begin : monitor
    logic [DATA_W-1:0] want;
    if (rst_n) begin
      if (evict_valid && evict_ready) begin
        if (exp_evict.size() == 0) begin
          report_error("evict response without an outstanding request");
        end else begin
          want = exp_evict.pop_front();
          check_word("evict_data_o", want, evict_data);
          resp_cnt++;
        end
      end
      if (read_valid && read_ready) begin
        if (exp_read.size() == 0) begin
          report_error("read response without an outstanding request");
        end else begin
          want = exp_read.pop_front();
          check_word("read_data_o", want, read_data);
          resp_cnt++;
        end
      end
      for (int u = 0; u < NUM_UNITS; u++) begin
        if (req_valid[u] && req_ready[u]) begin
          taken[u] = 1'b1;
          xfer_cnt[u]++;
          if (u == EVICT_UNIT) begin
            exp_evict.push_back(model_mem[lane_way[u]][req_line[u]]);
          end else if (u == RCHAN_UNIT) begin
            exp_read.push_back(model_mem[lane_way[u]][req_line[u]]);
          end else begin
            model_mem[lane_way[u]][req_line[u]] = req_data[u];  // refill or write channel
          end
        end
      end
    end
  end

  initial begin
    int base;
    clk         = 1'b0;
    rst_n       = 1'b0;
    req_way     = '0;
    req_line    = '0;
    req_data    = '0;
    req_valid   = '0;
    evict_ready = 1'b0;
    read_ready  = 1'b0;
    rng_state   = 32'h4a53dedf;
    ev_mode     = 2;
    rd_mode     = 2;
    errors      = 0;
    n_tests     = 0;
    resp_cnt    = 0;
    for (int u = 0; u < NUM_UNITS; u++) begin
      script_head[u] = 0;
      script_tail[u] = 0;
      lane_way[u]    = 0;
      lane_wait[u]   = 0;
      taken[u]       = 1'b0;
      xfer_cnt[u]    = 0;
    end
    foreach (model_mem[w, l]) begin
      model_mem[w][l] = '0;
    end
    repeat (2) @(negedge clk);
    rst_n = 1'b1;

    test_begin("reset_state");
    @(negedge clk);
    check_flag("evict_valid_o", 1'b0, evict_valid);
    check_flag("read_valid_o", 1'b0, read_valid);
    for (int u = 0; u < NUM_UNITS; u++) begin
      check_flag($sformatf("req_ready_o[%0d]", u), 1'b1, req_ready[u]);
    end
    test_end();

    test_begin("write_read");
    for (int i = 0; i < NUM_WAYS * NUM_LINES; i++) begin
      add_req((i % 2) ? WCHAN_UNIT : REFILL_UNIT, i / NUM_LINES, i % NUM_LINES, rand32());
    end
    run_until_idle(2000);
    for (int i = 0; i < NUM_WAYS * NUM_LINES; i++) begin
      add_req(RCHAN_UNIT, i / NUM_LINES, i % NUM_LINES, '0);
    end
    run_until_idle(2000);
    test_end();

    test_begin("order_across_ways");
    ev_mode = 0;
    rd_mode = 0;
    for (int i = 0; i < 60; i++) begin
      add_req(EVICT_UNIT, rand32() % NUM_WAYS, rand32() % NUM_LINES, '0);
      add_req(RCHAN_UNIT, rand32() % NUM_WAYS, rand32() % NUM_LINES, '0);
      if (i % 3 == 0) begin
        add_req(REFILL_UNIT, rand32() % NUM_WAYS, rand32() % NUM_LINES, rand32());
        add_req(WCHAN_UNIT, rand32() % NUM_WAYS, rand32() % NUM_LINES, rand32());
      end
    end
    run_until_idle(4000);
    @(negedge clk);
    check_flag("evict_valid_o at end", 1'b0, evict_valid);
    check_flag("read_valid_o at end", 1'b0, read_valid);
    test_end();

    test_begin("contention");
    for (int i = 0; i < 24; i++) begin
      for (int u = 0; u < NUM_UNITS; u++) begin
        add_req(u, 2, rand32() % NUM_LINES, rand32());  // every unit on way 2
      end
    end
    run_until_idle(4000);
    test_end();

    test_begin("outstanding_limit");
    ev_mode = 2;
    rd_mode = 1;
    base    = xfer_cnt[RCHAN_UNIT];
    for (int i = 0; i < NUM_WAYS; i++) begin
      add_req(RCHAN_UNIT, i, rand32() % NUM_LINES, '0);  // one read per way
    end
    for (int cyc = 0; cyc < 40; cyc++) begin
      @(negedge clk);
      if (xfer_cnt[RCHAN_UNIT] - base >= NUM_WAYS) begin
        check_flag("read unit req_ready_o while queue full", 1'b0, req_ready[RCHAN_UNIT]);
      end
      if (cyc == 20) begin
        // lane idle so far, now two more reads that must wait
        add_req(RCHAN_UNIT, 0, rand32() % NUM_LINES, '0);
        add_req(RCHAN_UNIT, 1, rand32() % NUM_LINES, '0);
      end
      drive_step();
    end
    if (xfer_cnt[RCHAN_UNIT] - base != NUM_WAYS) begin
      report_error($sformatf("read unit made %0d transfers while blocked, limit is %0d",
                             xfer_cnt[RCHAN_UNIT] - base, NUM_WAYS));
    end
    rd_mode = 2;
    run_until_idle(1000);
    test_end();

    $display("%0d tests, %0d errors, %0d responses checked", n_tests, errors, resp_cnt);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: verilog.f
rtl/llc_pkg.sv
rtl/llc_rr_arbiter.sv
rtl/llc_way_xbar.sv
rtl/llc_data_way.sv
rtl/llc_order_fifo.sv
rtl/llc_resp_router.sv
rtl/llc_ways.sv
bench/llc_ways_tb.sv
